//--- common/zx_bus_pkg.sv
// ======================================================================
// Types and constants of the CPU I/O side
// Port decode follows the partial decoding of the real machines, so
// several addresses alias onto one port
// ======================================================================

package zx_bus_pkg;

	// CPU port address and data byte
	typedef logic [15:0] io_addr_t;
	typedef logic [7:0]  io_data_t;

	// Floating bus value for reads nobody answers
	parameter io_data_t OPEN_BUS = 8'hFF;

	// ULA answers on every even port
	parameter int unsigned ULA_SEL_BIT = 0;

	// 7FFD decode bits
	parameter int unsigned PAGE_A15_BIT = 15;
	parameter int unsigned PAGE_A1_BIT  = 1;
	parameter int unsigned PAGE_A14_BIT = 14;

	// Top nibble of the +3 paging port 1FFD
	parameter logic [3:0] PLUS3_HI_NIBBLE = 4'b0001;

endpackage

//--- common/zx_mem_pkg.sv
// ======================================================================
// Memory map definitions shared by the paging registers and the mapper
// Physical space is 256 KB in 16 KB pages
// The upper half holds ROMs and the lower half holds the eight RAM banks
// ======================================================================

package zx_mem_pkg;

	// Machine model latched while reset is high
	typedef enum logic [1:0] {
		MACHINE_48K   = 2'd0,
		MACHINE_128K  = 2'd1,
		MACHINE_PLUS3 = 2'd2
	} machine_t;

	// 16 KB RAM bank or ROM number
	typedef logic [2:0] bank_t;

	// Bit 17 selects ROM, 16:14 bank, 13:0 offset
	typedef logic [17:0] ram_addr_t;

	// ==================================================================
	// 7FFD register layout
	// ==================================================================
	parameter int unsigned PG_BANK_LSB = 0;
	parameter int unsigned PG_SCREEN   = 3;
	parameter int unsigned PG_ROM      = 4;
	parameter int unsigned PG_LOCK     = 5;

	// ==================================================================
	// 1FFD register layout
	// ==================================================================
	parameter int unsigned P3_SPECIAL = 0;
	// Two bits of all-RAM configuration
	parameter int unsigned P3_CFG_LSB = 1;
	// Also the high ROM bit in normal mode
	parameter int unsigned P3_ROM_HI  = 2;

	// Banks hard wired into slots 1 and 2 in normal mode
	parameter bank_t BANK_SLOT1 = 3'd5;
	parameter bank_t BANK_SLOT2 = 3'd2;

	// 48K BASIC sits in the last ROM page
	parameter bank_t ROM_48K_NUM = 3'd3;

endpackage

//--- bus/apb_io_bridge.sv
// ======================================================================
// APB slave turning each transfer into a single I/O strobe
// Strobe fires in the first access cycle, pready follows one cycle later
// Exactly one wait state per transfer, pslverr never set
// No address decode here, the receivers decode their own ports
// ======================================================================
`timescale 1ns/1ns

module apb_io_bridge
	import zx_bus_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     psel,
	input  logic     penable,
	input  logic     pwrite,
	input  io_addr_t paddr,
	input  io_data_t pwdata,
	output logic     pready,
	output io_data_t prdata,
	output logic     pslverr,
	output logic     io_wr,
	output logic     io_rd,
	output io_addr_t io_addr,
	output io_data_t io_wdata,
	input  io_data_t io_rdata,
	input  logic     io_rhit
);

	// Set from setup until pready, so one transfer gives one strobe
	logic xfer_busy;
	logic setup_phase;

	assign setup_phase = psel & ~penable & ~xfer_busy;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			xfer_busy <= 1'b0;
			io_wr     <= 1'b0;
			io_rd     <= 1'b0;
			pready    <= 1'b0;
		end else begin
			io_wr  <= setup_phase & pwrite;
			io_rd  <= setup_phase & ~pwrite;
			// Wait state is the first access cycle
			pready <= psel & penable & xfer_busy & ~pready;
			if (setup_phase) begin
				xfer_busy <= 1'b1;
			end else if (pready) begin
				xfer_busy <= 1'b0;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk_sys) begin
		if (setup_phase) begin
			io_addr  <= paddr;
			io_wdata <= pwdata;
		end
		// Read data sampled while the strobe is out
		if (io_rd) begin
			prdata <= io_rhit ? io_rdata : OPEN_BUS;
		end
	end

	// Every port access is legal on a Spectrum
	assign pslverr = 1'b0;

endmodule

//--- paging/paging_regs.sv
// ======================================================================
// 128K and +3 paging registers with lock bit and machine latch
// Machine model follows the machine input only while reset is high
// Lock bit clears on reset only, writes are dropped on a 48K machine
// On a 128K machine A14 is not decoded, so 1FFD aliases onto 7FFD
// ======================================================================
`timescale 1ns/1ns

module paging_regs
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  machine_t machine,
	input  logic     io_wr,
	input  logic     io_rd,
	input  io_addr_t io_addr,
	input  io_data_t io_wdata,
	output io_data_t io_rdata,
	output logic     io_rhit,
	output io_data_t page_7ffd,
	output io_data_t page_1ffd,
	output machine_t cur_machine,
	output logic     screen_shadow
);

	logic is_plus3;
	logic is_48k;
	logic sel_7ffd;
	logic sel_1ffd;
	logic page_disable;

	assign is_plus3 = (cur_machine == MACHINE_PLUS3);
	assign is_48k   = (cur_machine == MACHINE_48K);

	// ==================================================================
	// Port decode
	// ==================================================================
	assign sel_7ffd = ~io_addr[PAGE_A15_BIT] & ~io_addr[PAGE_A1_BIT] &
		(io_addr[PAGE_A14_BIT] | ~is_plus3);
	assign sel_1ffd = (io_addr[PAGE_A15_BIT -: 4] == PLUS3_HI_NIBBLE) &
		~io_addr[PAGE_A1_BIT] & is_plus3;

	assign page_disable = page_7ffd[PG_LOCK] | is_48k;

	// Model sampled on each reset cycle
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cur_machine <= machine;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= '0;
		end else if (io_wr && !page_disable) begin
			if (sel_7ffd) begin
				page_7ffd <= io_wdata;
			end else if (sel_1ffd) begin
				page_1ffd <= io_wdata;
			end
		end
	end

	// Readback ignores the lock
	assign io_rhit  = io_rd & (sel_7ffd | sel_1ffd);
	assign io_rdata = sel_1ffd ? page_1ffd : page_7ffd;

	// Second screen lives in bank 7
	assign screen_shadow = page_7ffd[PG_SCREEN];

endmodule

//--- paging/mem_mapper.sv
// ======================================================================
// CPU memory request to physical RAM/ROM address, one cycle latency
// Accepts a request every cycle, results stream back to back
// Writes into the ROM region come out with ram_we low
// ======================================================================
`timescale 1ns/1ns

module mem_mapper
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        mem_valid,
	input  logic [15:0] mem_addr,
	input  logic        mem_wr,
	input  io_data_t    page_7ffd,
	input  io_data_t    page_1ffd,
	input  machine_t    cur_machine,
	output logic        ram_valid,
	output ram_addr_t   ram_addr,
	output logic        ram_we
);

	logic [1:0] slot;
	logic       special;
	logic       rom_sel;
	bank_t      rom_num;
	bank_t      bank;

	assign slot    = mem_addr[15:14];
	assign special = (cur_machine == MACHINE_PLUS3) & page_1ffd[P3_SPECIAL];

	always_comb begin
		case (cur_machine)
			MACHINE_48K:  rom_num = ROM_48K_NUM;
			MACHINE_128K: rom_num = {2'b00, page_7ffd[PG_ROM]};
			default:      rom_num = {1'b0, page_1ffd[P3_ROM_HI], page_7ffd[PG_ROM]};
		endcase
	end

	// ==================================================================
	// Slot to bank
	// ==================================================================
	always_comb begin
		rom_sel = 1'b0;
		if (special) begin
			// All-RAM configurations of the +3
			case (page_1ffd[P3_CFG_LSB +: 2])
				2'd0:    bank = {1'b0, slot};
				2'd1:    bank = {1'b1, slot};
				2'd2:    bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
				default: bank = (slot == 2'd3) ? 3'd3 :
					(slot == 2'd1) ? 3'd7 : {1'b1, slot};
			endcase
		end else begin
			case (slot)
				2'd0: begin
					rom_sel = 1'b1;
					bank    = rom_num;
				end
				2'd1:    bank = BANK_SLOT1;
				2'd2:    bank = BANK_SLOT2;
				default: bank = (cur_machine == MACHINE_48K) ? 3'd0 :
					page_7ffd[PG_BANK_LSB +: 3];
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ram_valid <= 1'b0;
			ram_we    <= 1'b0;
		end else begin
			ram_valid <= mem_valid;
			ram_we    <= mem_valid & mem_wr & ~rom_sel;
		end
	end

	// Region bit, bank and offset of the request
	always_ff @(posedge clk_sys) begin
		ram_addr <= {rom_sel, bank, mem_addr[13:0]};
	end

endmodule

//--- rtl/ula_port.sv
// ======================================================================
// ULA output port FE, decoded on A0 low only
// Border, MIC and EAR hold their value until the next write
// ======================================================================
`timescale 1ns/1ns

module ula_port
	import zx_bus_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_wr,
	input  io_addr_t   io_addr,
	input  io_data_t   io_wdata,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (io_wr && !io_addr[ULA_SEL_BIT]) begin
			border <= io_wdata[2:0];
			mic    <= io_wdata[3];
			ear    <= io_wdata[4];
		end
	end

endmodule

//--- rtl/zx_paging_top.sv
// ======================================================================
// Spectrum paging subsystem
// CPU I/O cycles arrive over APB, memory requests on a separate port
// Machine model is taken while reset is high
// ======================================================================
`timescale 1ns/1ns

module zx_paging_top
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  machine_t    machine,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  io_addr_t    paddr,
	input  io_data_t    pwdata,
	output logic        pready,
	output io_data_t    prdata,
	output logic        pslverr,
	input  logic        mem_valid,
	input  logic [15:0] mem_addr,
	input  logic        mem_wr,
	output logic        ram_valid,
	output ram_addr_t   ram_addr,
	output logic        ram_we,
	output logic [2:0]  border,
	output logic        ear,
	output logic        mic,
	output logic        screen_shadow
);

	// I/O strobe bus
	logic     io_wr;
	logic     io_rd;
	io_addr_t io_addr;
	io_data_t io_wdata;
	io_data_t io_rdata;
	logic     io_rhit;

	// Paging state
	io_data_t page_7ffd;
	io_data_t page_1ffd;
	machine_t cur_machine;

	apb_io_bridge apb_io_bridge_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.pready   (pready),
		.prdata   (prdata),
		.pslverr  (pslverr),
		.io_wr    (io_wr),
		.io_rd    (io_rd),
		.io_addr  (io_addr),
		.io_wdata (io_wdata),
		.io_rdata (io_rdata),
		.io_rhit  (io_rhit)
	);

	paging_regs paging_regs_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.io_wr         (io_wr),
		.io_rd         (io_rd),
		.io_addr       (io_addr),
		.io_wdata      (io_wdata),
		.io_rdata      (io_rdata),
		.io_rhit       (io_rhit),
		.page_7ffd     (page_7ffd),
		.page_1ffd     (page_1ffd),
		.cur_machine   (cur_machine),
		.screen_shadow (screen_shadow)
	);

	ula_port ula_port_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.io_wr    (io_wr),
		.io_addr  (io_addr),
		.io_wdata (io_wdata),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	mem_mapper mem_mapper_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.mem_valid   (mem_valid),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.page_7ffd   (page_7ffd),
		.page_1ffd   (page_1ffd),
		.cur_machine (cur_machine),
		.ram_valid   (ram_valid),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we)
	);

endmodule

//--- sim/zx_paging_model.svh
// ======================================================================
// Reference model of the paging subsystem for the testbench
// Pure functions, the caller keeps the 7FFD and 1FFD state
// Special mode banks come from a lookup table, slot 3 in the top bits
// ======================================================================
`ifndef ZX_PAGING_MODEL_SVH
`define ZX_PAGING_MODEL_SVH

function automatic bit hits_7ffd(input io_addr_t a, input machine_t m);
	return !a[15] && !a[1] && (a[14] || m != MACHINE_PLUS3);
endfunction

function automatic bit hits_1ffd(input io_addr_t a, input machine_t m);
	return a[15:12] == 4'b0001 && !a[1] && m == MACHINE_PLUS3;
endfunction

// Readback value, all ones when no register answers
function automatic io_data_t expected_read(input io_addr_t a, input machine_t m,
	input io_data_t p7, input io_data_t p1);
	if (hits_7ffd(a, m)) begin
		return p7;
	end else if (hits_1ffd(a, m)) begin
		return p1;
	end
	return 8'hFF;
endfunction

function automatic bank_t rom_number(input machine_t m, input io_data_t p7,
	input io_data_t p1);
	if (m == MACHINE_48K) begin
		return 3'd3;
	end else if (m == MACHINE_128K) begin
		return {2'b00, p7[4]};
	end
	return {1'b0, p1[2], p7[4]};
endfunction

function automatic ram_addr_t expected_addr(input logic [15:0] a, input machine_t m,
	input io_data_t p7, input io_data_t p1);
	logic [11:0] row;
	bank_t       b;
	logic        rom;
	int          idx;
	rom = 1'b0;
	idx = int'(a[15:14]);
	if (m == MACHINE_PLUS3 && p1[0]) begin
		case (p1[2:1])
			2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
			default: row = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		b = row[idx*3 +: 3];
	end else if (idx == 0) begin
		rom = 1'b1;
		b   = rom_number(m, p7, p1);
	end else if (idx == 1) begin
		b = 3'd5;
	end else if (idx == 2) begin
		b = 3'd2;
	end else begin
		b = (m == MACHINE_48K) ? 3'd0 : p7[2:0];
	end
	return {rom, b, a[13:0]};
endfunction

`endif

//--- sim/tb_zx_paging.sv
// ======================================================================
// Testbench for the paging subsystem
// Random stimulus from a fixed seed, checked against the model header
// Outputs are sampled on the falling edge, inputs change on the rising
// ======================================================================
`timescale 1ns/1ns

module tb_zx_paging
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
;

	`include "zx_paging_model.svh"

	localparam int RESET_CYCLES = 4;
	localparam int BURST        = 8;
	localparam int N_FE         = 24;
	localparam int N_PAGE       = 12;
	// Upper bound of APB transfers plus memory cycles over all tests
	localparam int XFER_COUNT = 3 * (4 * BURST + 1) + N_FE + (N_PAGE + 6) * (BURST + 3) +
		2 * BURST + N_PAGE * (BURST + 6) + 2 * (2 * BURST + 2) + N_PAGE * (BURST + 3);
	localparam int WATCHDOG_NS = XFER_COUNT * 10 * 20 + 2000;

	logic        clk_sys;
	logic        reset;
	machine_t    machine;
	logic        psel;
	logic        penable;
	logic        pwrite;
	io_addr_t    paddr;
	io_data_t    pwdata;
	logic        pready;
	io_data_t    prdata;
	logic        pslverr;
	logic        mem_valid;
	logic [15:0] mem_addr;
	logic        mem_wr;
	logic        ram_valid;
	ram_addr_t   ram_addr;
	logic        ram_we;
	logic [2:0]  border;
	logic        ear;
	logic        mic;
	logic        screen_shadow;

	integer seed = 28910;
	int     errors;
	int     checks;

	// Model state
	machine_t   m_machine;
	io_data_t   m_7ffd;
	io_data_t   m_1ffd;
	logic [2:0] m_border;
	logic       m_ear;
	logic       m_mic;

	// Expected memory results, one entry per request
	bit        exp_valid_q[$];
	ram_addr_t exp_addr_q[$];
	bit        exp_we_q[$];

	zx_paging_top zx_paging_top_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.machine       (machine),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.pready        (pready),
		.prdata        (prdata),
		.pslverr       (pslverr),
		.mem_valid     (mem_valid),
		.mem_addr      (mem_addr),
		.mem_wr        (mem_wr),
		.ram_valid     (ram_valid),
		.ram_addr      (ram_addr),
		.ram_we        (ram_we),
		.border        (border),
		.ear           (ear),
		.mic           (mic),
		.screen_shadow (screen_shadow)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired at %0t, a transfer or burst never completed", $time);
		$display("=== FAIL ===");
		$finish;
	end

	// ==================================================================
	// Compare tasks
	// ==================================================================
	task automatic check_byte(input string name, input io_data_t exp, input io_data_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %02h got %02h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input ram_addr_t exp, input ram_addr_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %05h got %05h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic close_test(input string name, input int errors_at_start);
		$display("test %-14s %0d errors", name, errors - errors_at_start);
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================
	task automatic apply_reset(input machine_t m);
		@(posedge clk_sys);
		reset     <= 1'b1;
		machine   <= m;
		psel      <= 1'b0;
		penable   <= 1'b0;
		mem_valid <= 1'b0;
		mem_wr    <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		m_machine = m;
		m_7ffd    = 8'h00;
		m_1ffd    = 8'h00;
		m_border  = 3'd0;
		m_ear     = 1'b0;
		m_mic     = 1'b0;
		@(negedge clk_sys);
	endtask

	// Full APB transfer, also checks the one wait state
	task automatic apb_transfer(input logic wr, input io_addr_t a, input io_data_t d,
		output io_data_t rd);
		int waited;
		waited = 0;
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= a;
		pwdata  <= d;
		@(posedge clk_sys);
		penable <= 1'b1;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!pready);
		rd = prdata;
		checks++;
		if (waited != 2) begin
			errors++;
			$display("At %0t pready came %0d cycles after penable rose instead of 2",
				$time, waited);
		end
		check_bit("pslverr", 1'b0, pslverr);
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic apb_write(input io_addr_t a, input io_data_t d);
		io_data_t unused_rd;
		apb_transfer(1'b1, a, d, unused_rd);
		if (!a[0]) begin
			m_border = d[2:0];
			m_mic    = d[3];
			m_ear    = d[4];
		end
		if (m_machine != MACHINE_48K && !m_7ffd[5]) begin
			if (hits_7ffd(a, m_machine)) begin
				m_7ffd = d;
			end else if (hits_1ffd(a, m_machine)) begin
				m_1ffd = d;
			end
		end
	endtask

	task automatic apb_read_check(input io_addr_t a);
		io_data_t rd;
		apb_transfer(1'b0, a, 8'h00, rd);
		check_byte("prdata", expected_read(a, m_machine, m_7ffd, m_1ffd), rd);
	endtask

	// Random requests streamed back to back, each result checked one cycle later
	task automatic run_mem_burst(input int n, input bit slot0_writes);
		logic [31:0] rnd;
		logic [15:0] a;
		logic        v;
		logic        w;
		ram_addr_t   ea;
		for (int i = 0; i <= n; i++) begin
			@(posedge clk_sys);
			if (i < n) begin
				rnd = $random(seed);
				a   = rnd[15:0];
				v   = rnd[17:16] != 2'b00;
				w   = rnd[18];
				if (slot0_writes) begin
					a = {2'b00, rnd[13:0]};
					v = 1'b1;
					w = 1'b1;
				end
				mem_valid <= v;
				mem_addr  <= a;
				mem_wr    <= w;
				ea = expected_addr(a, m_machine, m_7ffd, m_1ffd);
				exp_valid_q.push_back(v);
				exp_addr_q.push_back(ea);
				exp_we_q.push_back(v && w && !ea[17]);
			end else begin
				mem_valid <= 1'b0;
				mem_wr    <= 1'b0;
			end
			@(negedge clk_sys);
			if (i > 0) begin
				v  = exp_valid_q.pop_front();
				ea = exp_addr_q.pop_front();
				check_bit("ram_valid", v, ram_valid);
				check_bit("ram_we", exp_we_q.pop_front(), ram_we);
				if (v) begin
					check_addr("ram_addr", ea, ram_addr);
				end
			end
		end
	endtask

	task automatic check_ula;
		check_byte("border", {5'd0, m_border}, {5'd0, border});
		check_bit("ear", m_ear, ear);
		check_bit("mic", m_mic, mic);
	endtask

	// ==================================================================
	// Tests
	// ==================================================================
	task automatic test_reset_state(input machine_t m, input string name);
		int start;
		start = errors;
		apply_reset(m);
		check_ula();
		run_mem_burst(4 * BURST, 1'b0);
		close_test(name, start);
	endtask

	task automatic test_fe_port;
		int          start;
		logic [31:0] rnd;
		start = errors;
		apply_reset(MACHINE_48K);
		for (int i = 0; i < N_FE; i++) begin
			rnd = $random(seed);
			apb_write(rnd[15:0], rnd[23:16]);
			check_ula();
		end
		close_test("fe_port", start);
	endtask

	task automatic test_128k;
		int          start;
		logic [31:0] rnd;
		start = errors;
		apply_reset(MACHINE_128K);
		for (int i = 0; i < N_PAGE + 4; i++) begin
			rnd = $random(seed);
			// Last four go to 1FFD, which aliases onto 7FFD here
			apb_write((i < N_PAGE) ? 16'h7FFD : 16'h1FFD, rnd[7:0] & 8'hDF);
			check_bit("screen_shadow", m_7ffd[3], screen_shadow);
			run_mem_burst(BURST, 1'b0);
		end
		rnd = $random(seed);
		apb_write(16'h7FFD, rnd[7:0] | 8'h20);
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			apb_write(rnd[8] ? 16'h7FFD : 16'h1FFD, rnd[7:0]);
			check_bit("screen_shadow", m_7ffd[3], screen_shadow);
		end
		run_mem_burst(2 * BURST, 1'b0);
		close_test("paging_128k", start);
	endtask

	task automatic test_plus3;
		int          start;
		logic [31:0] rnd;
		start = errors;
		apply_reset(MACHINE_PLUS3);
		for (int i = 0; i < N_PAGE; i++) begin
			rnd = $random(seed);
			apb_write(16'h1FFD, rnd[7:0]);
			apb_write(16'h7FFD, rnd[15:8] & 8'hDF);
			apb_read_check(16'h7FFD);
			apb_read_check(16'h1FFD);
			apb_read_check(rnd[31:16]);
			run_mem_burst(BURST, 1'b0);
		end
		apb_read_check(16'hFFFF);
		close_test("paging_plus3", start);
	endtask

	task automatic test_write_protect;
		int          start;
		logic [31:0] rnd;
		start = errors;
		apply_reset(MACHINE_PLUS3);
		run_mem_burst(2 * BURST, 1'b1);
		rnd = $random(seed);
		apb_write(16'h1FFD, 8'h01 | (rnd[7:0] & 8'h06));
		run_mem_burst(2 * BURST, 1'b1);
		close_test("write_protect", start);
	endtask

	task automatic test_48k;
		int          start;
		logic [31:0] rnd;
		start = errors;
		apply_reset(MACHINE_48K);
		for (int i = 0; i < N_PAGE; i++) begin
			rnd = $random(seed);
			apb_write(16'h7FFD, rnd[7:0]);
			apb_write(16'h1FFD, rnd[15:8]);
			// Mapper ignores 7FFD on a 48K, so the register shows up here only
			check_bit("screen_shadow", m_7ffd[3], screen_shadow);
			run_mem_burst(BURST, 1'b0);
		end
		close_test("machine_48k", start);
	endtask

	initial begin
		errors    = 0;
		checks    = 0;
		reset     = 1'b1;
		machine   = MACHINE_48K;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = 16'h0000;
		pwdata    = 8'h00;
		mem_valid = 1'b0;
		mem_addr  = 16'h0000;
		mem_wr    = 1'b0;

		test_reset_state(MACHINE_48K, "reset_48k");
		test_reset_state(MACHINE_128K, "reset_128k");
		test_reset_state(MACHINE_PLUS3, "reset_plus3");
		test_fe_port();
		test_128k();
		test_plus3();
		test_write_protect();
		test_48k();

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+sim
common/zx_bus_pkg.sv
common/zx_mem_pkg.sv
bus/apb_io_bridge.sv
paging/paging_regs.sv
paging/mem_mapper.sv
rtl/ula_port.sv
rtl/zx_paging_top.sv
sim/tb_zx_paging.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ns -f compile.f \
	--top-module tb_zx_paging -o tb_zx_paging \
	&& ./obj_dir/tb_zx_paging | tee sim.log \
	&& grep -q "^=== PASS ===$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
